// File: rtl/sample_pack_consts.svh
`ifndef SAMPLE_PACK_CONSTS_SVH
`define SAMPLE_PACK_CONSTS_SVH

// Sample and lane geometry.
`define SP_SAMPLE_W 48 // Three packed lanes.
`define SP_LANE_W 16 // One channel value.
`define SP_LANES 3 // Lanes per sample.

// Output side.
`define SP_WORD_W 32 // Lane in low half, zero above.

// Sample buffer.
`define SP_FIFO_AW 3 // Depth of 8.

`endif

// File: rtl/sample_pack_pkg.sv
`include "sample_pack_consts.svh"

package sample_pack_pkg;

	// One input sample, lane 0 in the low bits.
	typedef logic [`SP_SAMPLE_W-1:0] sample_t;

	typedef logic [`SP_LANE_W-1:0] lane_t;

	typedef logic [`SP_WORD_W-1:0] word_t;

	typedef logic [1:0] lane_idx_t; // Lane number within a sample.

	// Splitter FSM.
	typedef enum logic [1:0] {
		SPLIT_IDLE, // Waiting for a stored sample.
		SPLIT_READ, // Pop issued, read data in flight.
		SPLIT_HOLD // Lanes presented to the serializer.
	} split_state_t;

	// Serializer FSM.
	typedef enum logic [2:0] {
		SER_IDLE,
		SER_W0, // Lane 0 word.
		SER_W1,
		SER_W2,
		SER_GAP // Drops wen_32 and busy.
	} ser_state_t;

endpackage

// File: rtl/lanes_if.sv
`timescale 1ns/1ps

interface lanes_if
	import sample_pack_pkg::*;
	();

	lane_t lane0; // Bits 15:0 of the sample.
	lane_t lane1;
	lane_t lane2; // Bits 47:32.
	logic start; // One-cycle pulse, lanes valid.
	logic busy; // Serializer owns the lanes.

	// Splitter side.
	modport split (
		output lane0,
		output lane1,
		output lane2,
		output start,
		input busy
	);

	// Serializer side.
	modport ser (
		input lane0,
		input lane1,
		input lane2,
		input start,
		output busy
	);

endinterface

// File: rtl/sample_fifo.sv
`timescale 1ns/1ps

`include "sample_pack_consts.svh"

module sample_fifo
	import sample_pack_pkg::*;
#(
	parameter int AW = `SP_FIFO_AW
) (
	input logic clk,
	input logic rst_n,

	input logic wen,
	input sample_t wdata,

	input logic pop,
	output sample_t rd_data,
	output logic empty,

	output logic overflow
);

	localparam int DEPTH = 1 << AW;

	sample_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;

	logic full;
	logic accept;

	assign full = (count == (AW+1)'(DEPTH));
	assign empty = (count == '0);

	// A pop in the same cycle frees the slot being written.
	assign accept = wen && (!full || pop);

	// Storage.
	always_ff @(posedge clk) begin
		if (accept) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// Registered read port, valid the cycle after pop.
	always_ff @(posedge clk) begin
		if (pop) begin
			rd_data <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (accept) begin
			wr_ptr <= wr_ptr + 1'b1; // Wraps at depth.
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Occupancy.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({accept, pop})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count; // Both or neither.
				end
			endcase
		end
	end

	// Sticky drop flag.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			overflow <= 1'b0;
		end else if (wen && !accept) begin
			overflow <= 1'b1;
		end
	end

endmodule

// File: rtl/lane_splitter.sv
`timescale 1ns/1ps

`include "sample_pack_consts.svh"

module lane_splitter
	import sample_pack_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic empty,
	input sample_t rd_data,
	output logic pop,

	lanes_if.split lanes
);

	split_state_t state;
	split_state_t state_nxt;

	lane_t slice [`SP_LANES];

	lane_t lane0_q;
	lane_t lane1_q;
	lane_t lane2_q;
	logic start_q;

	logic ser_free;

	// Cut the sample into lanes, lane 0 lowest.
	always_comb begin
		for (int i = 0; i < `SP_LANES; i++) begin
			slice[i] = rd_data[i*`SP_LANE_W +: `SP_LANE_W];
		end
	end

	// Start still pending counts as busy.
	assign ser_free = !start_q && !lanes.busy;

	assign pop = (state == SPLIT_IDLE) && !empty;

	always_comb begin
		state_nxt = state;
		case (state)
			SPLIT_IDLE: begin
				if (!empty) begin
					state_nxt = SPLIT_READ;
				end
			end
			SPLIT_READ: begin
				state_nxt = SPLIT_HOLD; // Read data lands now.
			end
			SPLIT_HOLD: begin
				if (ser_free) begin
					state_nxt = SPLIT_IDLE;
				end
			end
			default: begin
				state_nxt = SPLIT_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= SPLIT_IDLE;
			start_q <= 1'b0;
		end else begin
			state <= state_nxt;
			start_q <= (state == SPLIT_READ);
		end
	end

	// Lanes stay put until the next sample is read.
	always_ff @(posedge clk) begin
		if (state == SPLIT_READ) begin
			lane0_q <= slice[0];
			lane1_q <= slice[1];
			lane2_q <= slice[2];
		end
	end

	assign lanes.lane0 = lane0_q;
	assign lanes.lane1 = lane1_q;
	assign lanes.lane2 = lane2_q;
	assign lanes.start = start_q;

endmodule

// File: rtl/word_serializer.sv
`timescale 1ns/1ps

`include "sample_pack_consts.svh"

module word_serializer
	import sample_pack_pkg::*;
(
	input logic clk,
	input logic rst_n,

	lanes_if.ser lanes,

	output logic wen_32,
	output word_t wdata_32
);

	localparam lane_idx_t LAST_LANE = lane_idx_t'(`SP_LANES - 1);
	localparam int PAD_W = `SP_WORD_W - `SP_LANE_W;

	ser_state_t state;
	ser_state_t state_nxt;

	lane_idx_t sel;
	lane_t cur_lane;
	logic in_word;

	// Which lane the current state emits.
	always_comb begin
		in_word = 1'b1;
		sel = '0;
		case (state)
			SER_W0: begin
				sel = 2'd0;
			end
			SER_W1: begin
				sel = 2'd1;
			end
			SER_W2: begin
				sel = LAST_LANE;
			end
			default: begin
				in_word = 1'b0;
			end
		endcase
	end

	always_comb begin
		case (sel)
			2'd0: begin
				cur_lane = lanes.lane0;
			end
			2'd1: begin
				cur_lane = lanes.lane1;
			end
			default: begin
				cur_lane = lanes.lane2;
			end
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			SER_IDLE: begin
				if (lanes.start) begin
					state_nxt = SER_W0;
				end
			end
			SER_W0: begin
				state_nxt = SER_W1;
			end
			SER_W1: begin
				state_nxt = SER_W2;
			end
			SER_W2: begin
				state_nxt = SER_GAP;
			end
			default: begin
				state_nxt = SER_IDLE; // Gap and unused codes.
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= SER_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Result stage.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wen_32 <= 1'b0;
			wdata_32 <= '0;
		end else begin
			wen_32 <= in_word;
			if (in_word) begin
				wdata_32 <= {{PAD_W{1'b0}}, cur_lane}; // Upper half zero.
			end
		end
	end

	// Set on the start edge, cleared by the gap edge.
	assign lanes.busy = (state != SER_IDLE);

endmodule

// File: rtl/sample_pack_top.sv
`timescale 1ns/1ps

`include "sample_pack_consts.svh"

module sample_pack_top
	import sample_pack_pkg::*;
(
	input logic clk,
	input logic rst_n,

	// Sample input.
	input logic wen_48,
	input sample_t wdata_48,

	// Word output.
	output logic wen_32,
	output word_t wdata_32,

	output logic overflow // Sticky until reset.
);

	logic fifo_empty;
	logic fifo_pop;
	sample_t fifo_rdata;

	lanes_if lanes_bus ();

	sample_fifo #(
		.AW(`SP_FIFO_AW)
	) u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wen(wen_48),
		.wdata(wdata_48),
		.pop(fifo_pop),
		.rd_data(fifo_rdata),
		.empty(fifo_empty),
		.overflow(overflow)
	);

	lane_splitter u_splitter (
		.clk(clk),
		.rst_n(rst_n),
		.empty(fifo_empty),
		.rd_data(fifo_rdata),
		.pop(fifo_pop),
		.lanes(lanes_bus.split)
	);

	word_serializer u_serializer (
		.clk(clk),
		.rst_n(rst_n),
		.lanes(lanes_bus.ser),
		.wen_32(wen_32),
		.wdata_32(wdata_32)
	);

endmodule

// File: dv/sample_pack_checker.sv
`timescale 1ns/1ps

module sample_pack_checker (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic pop,
	input logic wen_32,
	input logic overflow
);

	int fail_count;

	initial begin
		fail_count = 0;
	end

	start_when_free: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
		else begin
			fail_count++;
			$error("start raised while the serializer was busy");
		end

	// Two cycles from start to the first word, then exactly three words.
	three_words: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> ##2 wen_32 ##1 wen_32 ##1 wen_32 ##1 !wen_32)
		else begin
			fail_count++;
			$error("word group after start was not three consecutive cycles");
		end

	words_need_start: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(wen_32) |-> $past(start, 2))
		else begin
			fail_count++;
			$error("word group began without a start");
		end

	// Next pop only once the serializer has let go.
	pop_when_free: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !busy && !start)
		else begin
			fail_count++;
			$error("pop issued while the serializer still held a sample");
		end

	overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n) !$fell(overflow))
		else begin
			fail_count++;
			$error("overflow fell outside reset");
		end

endmodule

bind sample_pack_top sample_pack_checker u_checker (
	.clk(clk),
	.rst_n(rst_n),
	.start(lanes_bus.start),
	.busy(lanes_bus.busy),
	.pop(fifo_pop),
	.wen_32(wen_32),
	.overflow(overflow)
);

// File: dv/sample_pack_tb.sv
`timescale 1ns/1ps

`include "sample_pack_consts.svh"

module sample_pack_tb
	import sample_pack_pkg::*;
	();

	parameter string TRACE_FILE = "dv/sample_pack_trace.txt";

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 1;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int FIFO_DEPTH = 1 << `SP_FIFO_AW;
	localparam int SLOT_CYCLES = 8; // Pop to next possible pop.

	logic clk;
	logic rst_n;
	logic wen_48;
	sample_t wdata_48;
	logic wen_32;
	word_t wdata_32;
	logic overflow;

	word_t exp_q [$];
	word_t drv_words [3]; // Expected words of the sample on the bus.
	int occ;
	int slot_left;
	logic exp_ovf;

	int word_errs;
	int flag_errs;
	int other_errs;

	sample_pack_top DUT (
		.clk(clk),
		.rst_n(rst_n),
		.wen_48(wen_48),
		.wdata_48(wdata_48),
		.wen_32(wen_32),
		.wdata_32(wdata_32),
		.overflow(overflow)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			word_errs++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			flag_errs++;
			$display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Entered and left 1 ns after a rising edge.
	task automatic apply_reset();
		rst_n = 1'b0;
		wen_48 = 1'b0;
		repeat (2) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		check_flag(wen_32, 1'b0, "wen_32 in reset");
		check_word(wdata_32, '0, "wdata_32 in reset");
		check_flag(overflow, 1'b0, "overflow in reset");
		rst_n = 1'b1;
	endtask

	task automatic drive_sample(input sample_t data, input word_t w0, input word_t w1,
			input word_t w2, input int idle);
		wen_48 = 1'b1;
		wdata_48 = data;
		drv_words[0] = w0;
		drv_words[1] = w1;
		drv_words[2] = w2;
		@(posedge clk);
		#DRIVE_DELAY;
		wen_48 = 1'b0;
		repeat (idle) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	// Occupancy model: the splitter takes one stored sample per slot.
	always @(posedge clk) begin : fifo_model
		logic take;
		logic keep;
		if (!rst_n) begin
			occ = 0;
			slot_left = 0;
			exp_ovf = 1'b0;
			exp_q.delete();
		end else begin
			take = (slot_left == 0) && (occ > 0);
			keep = wen_48 && ((occ < FIFO_DEPTH) || take);
			if (keep) begin
				for (int i = 0; i < 3; i++) begin
					exp_q.push_back(drv_words[i]);
				end
				occ++;
			end else if (wen_48) begin
				exp_ovf = 1'b1; // Dropped sample.
			end
			if (take) begin
				occ--;
				slot_left = SLOT_CYCLES - 1;
			end else if (slot_left > 0) begin
				slot_left--;
			end
		end
	end

	always @(negedge clk) begin : output_monitor
		word_t exp;
		if (rst_n) begin
			check_flag(overflow, exp_ovf, "overflow");
			if (wen_32) begin
				if (exp_q.size() == 0) begin
					other_errs++;
					$display("** Error at %0t ns: word %h arrived with no sample pending",
						$time, wdata_32);
				end else begin
					exp = exp_q.pop_front();
					check_word(wdata_32, exp, "wdata_32");
				end
			end
		end
	end

	initial begin : main
		int fd;
		int n;
		int idle;
		int waited;
		int total;
		string line;
		string op;
		sample_t data;
		word_t w0;
		word_t w1;
		word_t w2;
		rst_n = 1'b0;
		wen_48 = 1'b0;
		wdata_48 = '0;
		drv_words[0] = '0;
		drv_words[1] = '0;
		drv_words[2] = '0;
		word_errs = 0;
		flag_errs = 0;
		other_errs = 0;
		apply_reset();
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			other_errs++;
			$display("Could not open the trace file %s.", TRACE_FILE);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() == 0 || line.getc(0) == "#") begin
					continue;
				end
				n = $sscanf(line, "%s %h %d %h %h %h", op, data, idle, w0, w1, w2);
				if (n <= 0) begin
					continue; // Blank line.
				end
				if (n != 6) begin
					other_errs++;
					$display("A trace line could not be read: %s", line);
				end else if (op == "R") begin
					apply_reset();
				end else if (op == "W") begin
					drive_sample(data, w0, w1, w2, idle);
				end else begin
					other_errs++;
					$display("The trace holds an unknown operation %s.", op);
				end
			end
			$fclose(fd);
		end
		waited = 0;
		while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			other_errs++;
			$display("The output words stopped arriving with %0d words still expected.",
				exp_q.size());
		end
		repeat (SLOT_CYCLES) @(posedge clk); // Catch any extra words.
		total = word_errs + flag_errs + other_errs + DUT.u_checker.fail_count;
		$display("Errors: word %0d, flag %0d, other %0d, assertion %0d",
			word_errs, flag_errs, other_errs, DUT.u_checker.fail_count);
		if (total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: sample_pack.f
+incdir+rtl
rtl/sample_pack_pkg.sv
rtl/lanes_if.sv
rtl/sample_fifo.sv
rtl/lane_splitter.sv
rtl/word_serializer.sv
rtl/sample_pack_top.sv
dv/sample_pack_checker.sv
dv/sample_pack_tb.sv

// File: Makefile
# Verilator flow for sample_pack.

TOP ?= sample_pack_tb
FLIST ?= sample_pack.f
LOG ?= sim.log
TRACE ?= dv/sample_pack_trace.txt
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
SIMFLAGS ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -GTRACE_FILE='"$(TRACE)"'
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/sample_pack_trace.txt
# op sample(hex) idle_cycles(dec) word0 word1 word2
# W writes one sample, R pulses reset and ignores the other columns.
# Single samples with long idles.
W 123456789abc 12 00009abc 00005678 00001234
W 001122334455 12 00004455 00002233 00000011
W fedcba987654 12 00007654 0000ba98 0000fedc
# Back-to-back writes that fit.
W 000100020003 0 00000003 00000002 00000001
W 000400050006 0 00000006 00000005 00000004
W 000700080009 0 00000009 00000008 00000007
W 000a000b000c 40 0000000c 0000000b 0000000a
# Burst past the FIFO depth.
W c012c011c010 0 0000c010 0000c011 0000c012
W c022c021c020 0 0000c020 0000c021 0000c022
W c032c031c030 0 0000c030 0000c031 0000c032
W c042c041c040 0 0000c040 0000c041 0000c042
W c052c051c050 0 0000c050 0000c051 0000c052
W c062c061c060 0 0000c060 0000c061 0000c062
W c072c071c070 0 0000c070 0000c071 0000c072
W c082c081c080 0 0000c080 0000c081 0000c082
W c092c091c090 0 0000c090 0000c091 0000c092
W c0a2c0a1c0a0 0 0000c0a0 0000c0a1 0000c0a2
W c0b2c0b1c0b0 0 0000c0b0 0000c0b1 0000c0b2
W c0c2c0c1c0c0 100 0000c0c0 0000c0c1 0000c0c2
# Reset while words are in flight.
W d0a2d0a1d0a0 0 0000d0a0 0000d0a1 0000d0a2
W d0b2d0b1d0b0 4 0000d0b0 0000d0b1 0000d0b2
R 000000000000 0 00000000 00000000 00000000
W e0a2e0a1e0a0 12 0000e0a0 0000e0a1 0000e0a2
W e0b2e0b1e0b0 12 0000e0b0 0000e0b1 0000e0b2
# Edge patterns.
W ffffffffffff 12 0000ffff 0000ffff 0000ffff
W 000000000000 12 00000000 00000000 00000000
W aaaa5555aaaa 0 0000aaaa 00005555 0000aaaa
W 5555aaaa5555 0 00005555 0000aaaa 00005555
W 80000001ffff 20 0000ffff 00000001 00008000
